// ==== hdl/gb_map_pkg.sv ====
/*
 * memory map for the console glue: register addresses, region bits,
 * ram sizes, interrupt vector rules, serial timing and the select struct
 */
package gb_map_pkg;

	// ------------------------------------------------------------
	// bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// single registers in the io page
	localparam logic [15:0] ADDR_JOYP = 16'hFF00;	// joypad matrix
	localparam logic [15:0] ADDR_SB   = 16'hFF01;	// serial data, reads open bus
	localparam logic [15:0] ADDR_SC   = 16'hFF02;	// serial control
	localparam logic [15:0] ADDR_IF   = 16'hFF0F;	// interrupt flags
	localparam logic [15:0] ADDR_IE   = 16'hFFFF;	// interrupt enable

	// ------------------------------------------------------------
	// region decode, upper address bits
	localparam logic [1:0] WRAM_BASE_HI  = 2'b11;		// c000 up, echo included
	localparam logic [8:0] ZPRAM_BASE_HI = 9'h1FF;		// ff80..fffe
	localparam logic [2:0] CRAM_BASE_HI  = 3'b101;		// cart ram a000..bfff
	localparam logic [7:0] IO_PAGE       = 8'hFF;		// excluded from wram
	localparam int WRAM_AW  = 13;
	localparam int ZPRAM_AW = 7;

	// interrupts
	localparam int IRQ_N     = 5;
	localparam int IRQ_IDX_W = $clog2(IRQ_N);
	localparam logic [7:0] IRQ_VEC_BASE = 8'h40;
	localparam logic [7:0] IRQ_VEC_STEP = 8'd8;
	localparam logic [7:0] IRQ_VEC_NONE = 8'h55;	// nothing pending

	// serial stub, 8192 Hz bit clock at 4 MHz
	localparam int SERIAL_BIT_CYCLES = 512;
	localparam int SERIAL_BITS       = 8;
	localparam int SERIAL_DIV_W      = $clog2(SERIAL_BIT_CYCLES);
	localparam int SERIAL_CNT_W      = $clog2(SERIAL_BITS + 1);

	localparam logic [7:0] OPEN_BUS = 8'hFF;

	// one select bit per region, at most one set
	typedef struct packed {
		logic cart;
		logic wram;
		logic zpram;
		logic joyp;
		logic sb;
		logic sc;
		logic if_reg;
		logic ie_reg;
	} sel_t;

endpackage

// ==== hdl/gb_bus_pkg.sv ====
/*
 * bus structs: cpu side strobes, cartridge pins and the
 * interrupt source bundle in IF bit order
 */
package gb_bus_pkg;

	// plain strobe bus from the cpu, one access per cycle
	typedef struct packed {
		logic [gb_map_pkg::ADDR_W-1:0] addr;
		logic                          rd;
		logic                          wr;
		logic [gb_map_pkg::DATA_W-1:0] wdata;
	} cpu_bus_t;

	// ------------------------------------------------------------
	// cartridge rom / ram request, passed straight to the pins
	typedef struct packed {
		logic [gb_map_pkg::ADDR_W-1:0] addr;
		logic                          rd;
		logic                          wr;
		logic [gb_map_pkg::DATA_W-1:0] wdata;
	} cart_req_t;

	// event sources, first member is the msb so vblank lands on bit 0
	typedef struct packed {
		logic joypad;	// bit 4
		logic serial;	// bit 3
		logic timer;	// bit 2
		logic lcd;		// bit 1
		logic vblank;	// bit 0, raw level
	} irq_src_t;

endpackage

// ==== hdl/gb_bus_decode.sv ====
/*
 * cpu address decoder, cartridge strobes and the registered
 * read data mux with one cycle of latency
 */
`timescale 1ns/1ns

module gb_bus_decode (
	input  logic                    clk,
	input  logic                    reset,
	input  gb_bus_pkg::cpu_bus_t    cpu,
	output gb_map_pkg::sel_t        sel,
	output gb_bus_pkg::cart_req_t   cart,
	input  logic [7:0]              cart_do,
	input  logic [7:0]              joyp_rdata,
	input  logic [7:0]              sc_rdata,
	input  logic [7:0]              if_rdata,
	input  logic [7:0]              ie_rdata,
	input  logic [7:0]              ram_rdata,
	output logic [7:0]              rdata
);

	gb_map_pkg::sel_t rd_sel;	// region of the read in flight
	logic             rd_pend;	// read issued last cycle

	// ------------------------------------------------------------
	// address decode
	always_comb begin
		sel        = '0;
		sel.cart   = !cpu.addr[15] ||										// rom below 8000
			(cpu.addr[15:13] == gb_map_pkg::CRAM_BASE_HI);
		sel.wram   = (cpu.addr[15:14] == gb_map_pkg::WRAM_BASE_HI) &&
			(cpu.addr[15:8] != gb_map_pkg::IO_PAGE) &&					// echo aliases here
			(cpu.addr[15:8] != 8'hFE);										// oam page stays unmapped
		sel.zpram  = (cpu.addr[15:7] == gb_map_pkg::ZPRAM_BASE_HI) &&
			(cpu.addr != gb_map_pkg::ADDR_IE);
		sel.joyp   = cpu.addr == gb_map_pkg::ADDR_JOYP;
		sel.sb     = cpu.addr == gb_map_pkg::ADDR_SB;
		sel.sc     = cpu.addr == gb_map_pkg::ADDR_SC;
		sel.if_reg = cpu.addr == gb_map_pkg::ADDR_IF;
		sel.ie_reg = cpu.addr == gb_map_pkg::ADDR_IE;
	end

	// cartridge sees the cpu's own address and data
	assign cart = '{addr: cpu.addr, rd: cpu.rd & sel.cart, wr: cpu.wr & sel.cart,
		wdata: cpu.wdata};

	// ------------------------------------------------------------
	// read pipeline
	always_ff @(posedge clk) begin
		if (reset)
			rd_pend <= 1'b0;
		else
			rd_pend <= cpu.rd;
		if (cpu.rd)
			rd_sel <= sel;		// remember where the byte comes from
	end

	// byte is picked the cycle after the read, then held
	always_ff @(posedge clk) begin
		if (rd_pend) begin
			if (rd_sel.cart)
				rdata <= cart_do;
			else if (rd_sel.wram || rd_sel.zpram)
				rdata <= ram_rdata;						// sync ram output
			else if (rd_sel.joyp)
				rdata <= joyp_rdata;
			else if (rd_sel.sb)
				rdata <= gb_map_pkg::OPEN_BUS;			// no link partner
			else if (rd_sel.sc)
				rdata <= sc_rdata;
			else if (rd_sel.if_reg)
				rdata <= if_rdata;
			else if (rd_sel.ie_reg)
				rdata <= ie_rdata;
			else
				rdata <= gb_map_pkg::OPEN_BUS;			// unmapped
		end
	end

	// cpu never strobes both directions at once
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
		!(cpu.rd && cpu.wr));

endmodule

// ==== hdl/gb_irq_ctrl.sv ====
/*
 * interrupt controller: IF and IE registers, vblank edge capture,
 * fixed priority vector and acknowledge clearing
 */
`timescale 1ns/1ns

module gb_irq_ctrl (
	input  logic                    clk,
	input  logic                    reset,
	input  gb_bus_pkg::cpu_bus_t    cpu,
	input  gb_map_pkg::sel_t        sel,
	input  gb_bus_pkg::irq_src_t    src,
	input  logic                    irq_ack,
	output logic [7:0]              if_rdata,
	output logic [7:0]              ie_rdata,
	output logic [7:0]              irq_vec,
	output logic                    irq_pending
);

	logic [gb_map_pkg::IRQ_N-1:0]     if_r;		// flags
	logic [gb_map_pkg::IRQ_N-1:0]     ie_r;		// enables
	logic [gb_map_pkg::IRQ_N-1:0]     src_set;	// set requests this cycle
	logic [gb_map_pkg::IRQ_N-1:0]     hit;		// enabled and flagged
	logic [gb_map_pkg::IRQ_N-1:0]     ack_mask;	// one hot, winning bit
	logic [gb_map_pkg::IRQ_IDX_W-1:0] hit_idx;
	logic                             vb_d;		// vblank last cycle

	// ------------------------------------------------------------
	// sources, vblank is a level so only its rising edge counts
	always_comb begin
		src_set    = src;
		src_set[0] = src.vblank & ~vb_d;
	end

	// lowest bit wins
	always_comb begin
		hit      = if_r & ie_r;
		hit_idx  = '0;
		ack_mask = '0;
		for (int i = gb_map_pkg::IRQ_N - 1; i >= 0; i--) begin
			if (hit[i])
				hit_idx = gb_map_pkg::IRQ_IDX_W'(i);
		end
		ack_mask[hit_idx] = |hit;
	end

	assign irq_pending = |hit;
	assign irq_vec = irq_pending ?
		gb_map_pkg::IRQ_VEC_BASE + gb_map_pkg::IRQ_VEC_STEP *
			{{(8 - gb_map_pkg::IRQ_IDX_W){1'b0}}, hit_idx} :
		gb_map_pkg::IRQ_VEC_NONE;

	// ------------------------------------------------------------
	// registers, cpu write to IF beats set and ack
	always_ff @(posedge clk) begin
		if (reset) begin
			if_r <= '0;
			ie_r <= '0;
			vb_d <= 1'b0;
		end else begin
			vb_d <= src.vblank;
			if (cpu.wr && sel.ie_reg)
				ie_r <= cpu.wdata[gb_map_pkg::IRQ_N-1:0];
			if (cpu.wr && sel.if_reg)
				if_r <= cpu.wdata[gb_map_pkg::IRQ_N-1:0];
			else
				if_r <= (if_r | src_set) & ~(irq_ack ? ack_mask : '0);	// ack clears winner
		end
	end

	assign if_rdata = {3'b111, if_r};	// unused bits read high
	assign ie_rdata = {3'b000, ie_r};

	// cpu only acknowledges what it was told about
	a_ack_pending: assert property (@(posedge clk) disable iff (reset)
		irq_ack |-> irq_pending);

endmodule

// ==== hdl/gb_joypad.sv ====
/*
 * joypad register with matrix select, active low key readback and
 * the key press interrupt on a falling input line
 */
`timescale 1ns/1ns

module gb_joypad (
	input  logic                    clk,
	input  logic                    reset,
	input  gb_bus_pkg::cpu_bus_t    cpu,
	input  gb_map_pkg::sel_t        sel,
	input  logic [7:0]              joystick,	// active high
	output logic [7:0]              joyp_rdata,
	output logic                    key_irq
);

	logic [1:0] p54;		// select bits where low enables a half
	logic [3:0] joy_p4;		// directions
	logic [3:0] joy_p5;		// buttons
	logic [7:0] in_d;		// line history stage 1
	logic [7:0] in_d2;		// stage 2

	// ------------------------------------------------------------
	// matrix halves with the disabled half reading all ones
	assign joy_p4 = ~joystick[3:0] | {4{p54[0]}};	// right left up down from bit 0
	assign joy_p5 = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};

	assign joyp_rdata = {2'b11, p54, joy_p4 & joy_p5};

	always_ff @(posedge clk) begin
		if (reset) begin
			p54   <= 2'b00;
			in_d  <= 8'hFF;		// idle lines are high
			in_d2 <= 8'hFF;
		end else begin
			if (cpu.wr && sel.joyp)
				p54 <= cpu.wdata[5:4];
			in_d  <= {joy_p4, joy_p5};
			in_d2 <= in_d;
		end
	end

	// one to zero on any line
	assign key_irq = |(in_d2 & ~in_d);

endmodule

// ==== hdl/gb_serial.sv ====
/*
 * serial port stub: SC register and an internal clock transfer timer
 * that raises the serial interrupt after eight bit times
 */
`timescale 1ns/1ns

module gb_serial (
	input  logic                    clk,
	input  logic                    reset,
	input  gb_bus_pkg::cpu_bus_t    cpu,
	input  gb_map_pkg::sel_t        sel,
	output logic [7:0]              sc_rdata,
	output logic                    serial_irq
);

	logic                                sc_start;	// transfer running
	logic                                sc_clk;	// internal clock
	logic [gb_map_pkg::SERIAL_DIV_W-1:0] bit_div;	// cycles left in bit
	logic [gb_map_pkg::SERIAL_CNT_W-1:0] bit_cnt;	// bits left

	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		serial_irq <= 1'b0;
		if (reset) begin
			sc_start <= 1'b0;
			sc_clk   <= 1'b0;
			bit_div  <= '0;
			bit_cnt  <= '0;
		end else if (cpu.wr && sel.sc) begin
			sc_start <= cpu.wdata[7];
			sc_clk   <= cpu.wdata[0];
			if (cpu.wdata[7]) begin		// start loads the timer
				bit_div <= gb_map_pkg::SERIAL_DIV_W'(gb_map_pkg::SERIAL_BIT_CYCLES - 1);
				bit_cnt <= gb_map_pkg::SERIAL_CNT_W'(gb_map_pkg::SERIAL_BITS);
			end
		end else if (sc_start && sc_clk) begin
			bit_div <= bit_div - gb_map_pkg::SERIAL_DIV_W'(1);	// wraps every bit
			if (bit_div == '0 && bit_cnt != '0)
				bit_cnt <= bit_cnt - gb_map_pkg::SERIAL_CNT_W'(1);
			if (bit_cnt == '0) begin
				serial_irq <= 1'b1;		// transfer done
				sc_start   <= 1'b0;
				bit_div    <= gb_map_pkg::SERIAL_DIV_W'(gb_map_pkg::SERIAL_BIT_CYCLES - 1);
				bit_cnt    <= gb_map_pkg::SERIAL_CNT_W'(gb_map_pkg::SERIAL_BITS);
			end
		end
	end

	assign sc_rdata = {sc_start, 6'h3F, sc_clk};

	// counter stays inside one byte
	a_bit_cnt_range: assert property (@(posedge clk) disable iff (reset)
		bit_cnt <= gb_map_pkg::SERIAL_CNT_W'(gb_map_pkg::SERIAL_BITS));

endmodule

// ==== hdl/gb_work_ram.sv ====
/*
 * internal work ram (8 KB, echoed) and zero page ram,
 * both single port with a synchronous read
 */
`timescale 1ns/1ns

module gb_work_ram (
	input  logic                    clk,
	input  gb_bus_pkg::cpu_bus_t    cpu,
	input  gb_map_pkg::sel_t        sel,
	output logic [7:0]              ram_rdata
);

	logic [7:0] wram  [0:2**gb_map_pkg::WRAM_AW-1];
	logic [7:0] zpram [0:2**gb_map_pkg::ZPRAM_AW-1];	// top byte is IE, never hit
	logic [7:0] wram_q;
	logic [7:0] zpram_q;
	logic       zp_q;		// zero page was selected last cycle

	// ------------------------------------------------------------
	// work ram, c000 and e000 share the low 13 bits
	always_ff @(posedge clk) begin
		if (cpu.wr && sel.wram)
			wram[cpu.addr[gb_map_pkg::WRAM_AW-1:0]] <= cpu.wdata;
		wram_q <= wram[cpu.addr[gb_map_pkg::WRAM_AW-1:0]];
	end

	// zero page ff80..fffe
	always_ff @(posedge clk) begin
		if (cpu.wr && sel.zpram)
			zpram[cpu.addr[gb_map_pkg::ZPRAM_AW-1:0]] <= cpu.wdata;
		zpram_q <= zpram[cpu.addr[gb_map_pkg::ZPRAM_AW-1:0]];
		zp_q    <= sel.zpram;
	end

	assign ram_rdata = zp_q ? zpram_q : wram_q;

endmodule

// ==== hdl/gb_io_top.sv ====
/*
 * console io glue top: decoder, interrupt controller, joypad,
 * serial stub and internal rams on one cpu bus
 */
`timescale 1ns/1ns

module gb_io_top (
	input  logic                    clk,
	input  logic                    reset,
	input  gb_bus_pkg::cpu_bus_t    cpu,
	input  logic                    irq_ack,
	input  logic [7:0]              joystick,
	input  logic                    vblank,		// level
	input  logic                    lcd_irq,	// pulse
	input  logic                    timer_irq,	// pulse
	input  logic [7:0]              cart_do,
	output logic [7:0]              rdata,
	output logic [7:0]              irq_vec,
	output logic                    irq_pending,
	output gb_bus_pkg::cart_req_t   cart
);

	gb_map_pkg::sel_t sel;
	logic [7:0]       joyp_rdata, sc_rdata, if_rdata, ie_rdata, ram_rdata;
	logic             key_irq, serial_irq;

	// ------------------------------------------------------------
	gb_bus_decode u_bus_decode (
		.clk(clk), .reset(reset), .cpu(cpu), .sel(sel), .cart(cart),
		.cart_do(cart_do), .joyp_rdata(joyp_rdata), .sc_rdata(sc_rdata),
		.if_rdata(if_rdata), .ie_rdata(ie_rdata), .ram_rdata(ram_rdata),
		.rdata(rdata)
	);

	// sources in IF bit order
	gb_irq_ctrl u_irq_ctrl (
		.clk(clk), .reset(reset), .cpu(cpu), .sel(sel),
		.src(gb_bus_pkg::irq_src_t'{joypad: key_irq, serial: serial_irq,
			timer: timer_irq, lcd: lcd_irq, vblank: vblank}),
		.irq_ack(irq_ack), .if_rdata(if_rdata), .ie_rdata(ie_rdata),
		.irq_vec(irq_vec), .irq_pending(irq_pending)
	);

	gb_joypad u_joypad (
		.clk(clk), .reset(reset), .cpu(cpu), .sel(sel), .joystick(joystick),
		.joyp_rdata(joyp_rdata), .key_irq(key_irq)
	);

	gb_serial u_serial (
		.clk(clk), .reset(reset), .cpu(cpu), .sel(sel),
		.sc_rdata(sc_rdata), .serial_irq(serial_irq)
	);

	gb_work_ram u_work_ram (
		.clk(clk), .cpu(cpu), .sel(sel), .ram_rdata(ram_rdata)
	);

endmodule

// ==== dv/gb_io_checker.sv ====
/*
 * checker: compares read data one cycle after each read,
 * cart pins every cycle and the vector when asked
 */
`timescale 1ns/1ns

module gb_io_checker (
	input  logic                  clk,
	input  logic                  reset,
	input  gb_bus_pkg::cpu_bus_t  cpu,
	input  logic [7:0]            rdata,
	input  logic [7:0]            irq_vec,
	input  logic                  irq_pending,
	input  gb_bus_pkg::cart_req_t cart,
	input  logic [7:0]            exp_rdata,
	input  gb_bus_pkg::cart_req_t exp_cart,
	input  logic                  vec_chk,
	input  logic [7:0]            exp_vec,
	input  logic                  exp_pending,
	output int                    err_count
);

	logic        rd_q1, rd_q2;		// read two edges back
	logic [7:0]  exp_q1, exp_q2;
	logic [15:0] addr_q1, addr_q2;
	int          errs = 0;

	assign err_count = errs;

	// ------------------------------------------------------------
	// follow each read until its byte is on rdata
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_q1 <= 1'b0;
			rd_q2 <= 1'b0;
		end else begin
			rd_q1 <= cpu.rd;
			rd_q2 <= rd_q1;
		end
		exp_q1  <= exp_rdata;
		exp_q2  <= exp_q1;
		addr_q1 <= cpu.addr;
		addr_q2 <= addr_q1;
	end

	// mid cycle, everything settled
	always @(negedge clk) begin
		if (!reset) begin
			if (rd_q2 && rdata !== exp_q2) begin
				errs++;
				$display("ERROR @%0t: read of %h returned %h, expected %h",
					$time, addr_q2, rdata, exp_q2);
			end
			if (cart !== exp_cart) begin
				errs++;
				$display("ERROR @%0t: cart pins %h, expected %h", $time, cart, exp_cart);
			end
			if (vec_chk && (irq_vec !== exp_vec || irq_pending !== exp_pending)) begin
				errs++;
				$display("ERROR @%0t: vector %h pending %b, expected %h pending %b",
					$time, irq_vec, irq_pending, exp_vec, exp_pending);
			end
		end
	end

endmodule

// ==== dv/tb_gb_io.sv ====
/*
 * testbench for the console io glue with bus tasks, a shadow model
 * of rams and registers and the expected read data
 */
`timescale 1ns/1ns

module tb_gb_io;

	logic                  clk;
	logic                  reset;
	gb_bus_pkg::cpu_bus_t  cpu;
	logic                  irq_ack;
	logic [7:0]            joystick;
	logic                  vblank, lcd_irq, timer_irq;
	logic [7:0]            cart_do;
	logic [7:0]            rdata, irq_vec;
	logic                  irq_pending;
	gb_bus_pkg::cart_req_t cart;

	// expected values handed to the checker
	logic [7:0]            exp_rdata;
	gb_bus_pkg::cart_req_t exp_cart;
	logic                  vec_chk;		// compare vector this cycle
	logic [7:0]            exp_vec;
	logic                  exp_pending;
	int                    err_count;

	// shadow state
	logic [7:0]  wram_sh [0:8191];
	logic [7:0]  zp_sh [0:127];
	logic [1:0]  p54_sh;
	logic        sc_start_sh, sc_clk_sh;
	logic [4:0]  if_sh, ie_sh;
	logic [15:0] written [$];		// ram addresses already written

	integer      seed;
	logic [31:0] rnd;
	logic [15:0] addr;
	int          timeouts;
	int          i;
	int          s;

	gb_io_top u_gb_io_top (
		.clk(clk), .reset(reset), .cpu(cpu), .irq_ack(irq_ack), .joystick(joystick),
		.vblank(vblank), .lcd_irq(lcd_irq), .timer_irq(timer_irq), .cart_do(cart_do),
		.rdata(rdata), .irq_vec(irq_vec), .irq_pending(irq_pending), .cart(cart)
	);

	gb_io_checker u_checker (
		.clk(clk), .reset(reset), .cpu(cpu), .rdata(rdata), .irq_vec(irq_vec),
		.irq_pending(irq_pending), .cart(cart), .exp_rdata(exp_rdata),
		.exp_cart(exp_cart), .vec_chk(vec_chk), .exp_vec(exp_vec),
		.exp_pending(exp_pending), .err_count(err_count)
	);

	always #5 clk = ~clk;

	// ------------------------------------------------------------
	// reference model
	function automatic logic is_cart(input logic [15:0] a);
		return !a[15] || (a >= 16'hA000 && a <= 16'hBFFF);	// rom or cart ram
	endfunction

	function automatic logic [7:0] expected_rdata(input logic [15:0] a);
		logic [3:0] dirs;
		logic [3:0] btns;
		logic [7:0] v;
		dirs = 4'hF;		// disabled half reads ones
		btns = 4'hF;
		v    = gb_map_pkg::OPEN_BUS;
		if (!p54_sh[0])
			dirs = ~joystick[3:0];		// right, left, up, down
		if (!p54_sh[1])
			btns = ~joystick[7:4];		// a, b, select, start
		if (is_cart(a))
			v = cart_do;
		else if (a >= 16'hC000 && a <= 16'hFDFF)
			v = wram_sh[a[12:0]];		// echo shares the offset
		else if (a >= 16'hFF80 && a != gb_map_pkg::ADDR_IE)
			v = zp_sh[a[6:0]];
		else begin
			case (a)
				gb_map_pkg::ADDR_JOYP: v = {2'b11, p54_sh, dirs & btns};
				gb_map_pkg::ADDR_SC:   v = {sc_start_sh, 6'h3F, sc_clk_sh};
				gb_map_pkg::ADDR_IF:   v = {3'b111, if_sh};
				gb_map_pkg::ADDR_IE:   v = {3'b000, ie_sh};
				default:               v = gb_map_pkg::OPEN_BUS;	// sb too
			endcase
		end
		return v;
	endfunction

	// lowest common bit picks the vector
	function automatic logic [7:0] expected_vec(input logic [4:0] f, input logic [4:0] e);
		logic [4:0] both;
		logic [7:0] v;
		both = f & e;
		v    = gb_map_pkg::IRQ_VEC_NONE;
		for (int k = 4; k >= 0; k--) begin
			if (both[k])
				v = gb_map_pkg::IRQ_VEC_BASE + gb_map_pkg::IRQ_VEC_STEP * 8'(k);
		end
		return v;
	endfunction

	function automatic logic [4:0] ack_clear(input logic [4:0] f, input logic [4:0] e);
		logic [4:0] both;
		both = f & e;
		return f & ~(both & -both);		// drop lowest common bit
	endfunction

	// ------------------------------------------------------------
	// bus tasks drive inputs 1 ns after the edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic drive_bus(input logic [15:0] a, input logic r, input logic w,
		input logic [7:0] d);
		cpu       = '{addr: a, rd: r, wr: w, wdata: d};
		exp_cart  = '{addr: a, rd: r & is_cart(a), wr: w & is_cart(a), wdata: d};
		exp_rdata = r ? expected_rdata(a) : 8'h00;
	endtask

	task automatic note_write(input logic [15:0] a, input logic [7:0] d);
		if (a >= 16'hC000 && a <= 16'hFDFF)
			wram_sh[a[12:0]] = d;
		else if (a >= 16'hFF80 && a != gb_map_pkg::ADDR_IE)
			zp_sh[a[6:0]] = d;
		else begin
			case (a)
				gb_map_pkg::ADDR_JOYP: p54_sh = d[5:4];
				gb_map_pkg::ADDR_SC: begin
					sc_start_sh = d[7];
					sc_clk_sh   = d[0];
				end
				gb_map_pkg::ADDR_IF: if_sh = d[4:0];
				gb_map_pkg::ADDR_IE: ie_sh = d[4:0];
				default: ;
			endcase
		end
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		drive_bus(a, 1'b0, 1'b1, d);
		step();
		note_write(a, d);
		drive_bus(16'h0000, 1'b0, 1'b0, 8'h00);
	endtask

	task automatic bus_read(input logic [15:0] a);
		drive_bus(a, 1'b1, 1'b0, 8'h00);
		step();
		drive_bus(16'h0000, 1'b0, 1'b0, 8'h00);
		step();		// byte lands on rdata before inputs move
	endtask

	task automatic check_vec();
		exp_vec     = expected_vec(if_sh, ie_sh);
		exp_pending = |(if_sh & ie_sh);
		vec_chk     = 1'b1;
		step();
		vec_chk     = 1'b0;
	endtask

	task automatic wait_pending(input int limit, input string what);
		int n;
		n = 0;
		while (!irq_pending && n < limit) begin
			step();
			n++;
		end
		if (!irq_pending) begin
			timeouts++;
			$display("timeout: irq_pending did not rise while waiting for %s", what);
		end
	endtask

	// ------------------------------------------------------------
	initial begin
		clk = 1'b0;
		reset = 1'b1;
		cpu = '0;
		irq_ack = 1'b0;
		joystick = 8'h00;
		vblank = 1'b0;
		lcd_irq = 1'b0;
		timer_irq = 1'b0;
		cart_do = 8'h00;
		exp_rdata = 8'h00;
		exp_cart = '0;
		vec_chk = 1'b0;
		exp_vec = gb_map_pkg::IRQ_VEC_NONE;
		exp_pending = 1'b0;
		p54_sh = 2'b00;
		sc_start_sh = 1'b0;
		sc_clk_sh = 1'b0;
		if_sh = 5'd0;
		ie_sh = 5'd0;
		seed = 59076;
		timeouts = 0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		// rams through both echo and base aliases
		for (i = 0; i < 48; i++) begin
			rnd = $random(seed);
			if (rnd[8]) begin
				addr = 16'hFF80 | {9'h000, rnd[6:0]};
				if (addr == gb_map_pkg::ADDR_IE)
					addr = 16'hFF80;
			end else begin
				addr = 16'hC000 | {3'b000, rnd[12:0]};
				if (rnd[9] && addr < 16'hDE00)
					addr = addr + 16'h2000;		// write through echo
			end
			bus_write(addr, rnd[23:16]);
			written.push_back(addr);
		end
		foreach (written[j]) begin
			rnd  = $random(seed);
			addr = written[j];
			if (addr < 16'hFF00) begin
				addr = 16'hC000 | (addr & 16'h1FFF);
				if (rnd[0] && addr < 16'hDE00)
					addr = addr + 16'h2000;
			end
			bus_read(addr);
		end

		// fixed register bits, sb and unmapped reads
		bus_read(gb_map_pkg::ADDR_IE);
		bus_read(gb_map_pkg::ADDR_IF);
		bus_write(gb_map_pkg::ADDR_IE, 8'hFF);
		bus_write(gb_map_pkg::ADDR_IF, 8'hFF);
		bus_read(gb_map_pkg::ADDR_IE);
		bus_read(gb_map_pkg::ADDR_IF);
		bus_write(gb_map_pkg::ADDR_IE, 8'h00);
		bus_write(gb_map_pkg::ADDR_IF, 8'h00);
		bus_write(gb_map_pkg::ADDR_SB, 8'h5A);
		bus_read(gb_map_pkg::ADDR_SB);
		bus_read(16'h8000);
		bus_read(16'h9ABC);
		bus_write(16'hFE00, 8'hA5);		// above the echo, no ram here
		bus_read(16'hFE00);
		bus_read(16'hFE9F);
		bus_read(16'hFF03);
		bus_read(16'hFF40);
		bus_read(16'hFF7F);

		// priority vector and acknowledge
		check_vec();
		bus_write(gb_map_pkg::ADDR_IE, 8'h16);
		bus_write(gb_map_pkg::ADDR_IF, 8'h1D);
		check_vec();
		for (i = 0; i < gb_map_pkg::IRQ_N; i++) begin
			if ((if_sh & ie_sh) != 5'd0) begin
				irq_ack = 1'b1;
				step();
				irq_ack = 1'b0;
				if_sh = ack_clear(if_sh, ie_sh);
				check_vec();
			end
		end
		bus_read(gb_map_pkg::ADDR_IF);
		bus_write(gb_map_pkg::ADDR_IE, 8'h00);
		bus_write(gb_map_pkg::ADDR_IF, 8'h00);
		lcd_irq = 1'b1;
		step();
		lcd_irq = 1'b0;
		if_sh[1] = 1'b1;
		bus_read(gb_map_pkg::ADDR_IF);
		timer_irq = 1'b1;
		step();
		timer_irq = 1'b0;
		if_sh[2] = 1'b1;
		bus_read(gb_map_pkg::ADDR_IF);
		vblank = 1'b1;		// level input whose rise sets the flag
		step();
		if_sh[0] = 1'b1;
		bus_read(gb_map_pkg::ADDR_IF);
		vblank = 1'b0;
		bus_write(gb_map_pkg::ADDR_IF, 8'h00);

		// joypad matrix for each select setting
		for (s = 0; s < 4; s++) begin
			bus_write(gb_map_pkg::ADDR_JOYP, 8'(s << 4));
			for (i = 0; i < 8; i++) begin
				rnd = $random(seed);
				joystick = rnd[7:0];
				bus_read(gb_map_pkg::ADDR_JOYP);
			end
		end
		joystick = 8'h00;
		bus_write(gb_map_pkg::ADDR_JOYP, 8'h10);	// buttons only
		repeat (3) step();
		bus_write(gb_map_pkg::ADDR_IF, 8'h00);
		bus_write(gb_map_pkg::ADDR_IE, 8'h10);
		joystick = 8'h10;		// press a
		wait_pending(8, "key press");
		if_sh[4] = 1'b1;
		bus_read(gb_map_pkg::ADDR_IF);
		joystick = 8'h00;
		bus_write(gb_map_pkg::ADDR_IE, 8'h00);
		bus_write(gb_map_pkg::ADDR_IF, 8'h00);

		// serial with internal clock then external clock
		bus_write(gb_map_pkg::ADDR_IE, 8'h08);
		bus_write(gb_map_pkg::ADDR_SC, 8'h81);
		wait_pending((gb_map_pkg::SERIAL_BITS + 1) * gb_map_pkg::SERIAL_BIT_CYCLES,
			"serial transfer");
		if_sh[3] = 1'b1;
		sc_start_sh = 1'b0;		// transfer done
		bus_read(gb_map_pkg::ADDR_IF);
		bus_read(gb_map_pkg::ADDR_SC);
		bus_write(gb_map_pkg::ADDR_IF, 8'h00);
		bus_write(gb_map_pkg::ADDR_SC, 8'h80);
		for (i = 0; i < (gb_map_pkg::SERIAL_BITS + 1) * gb_map_pkg::SERIAL_BIT_CYCLES; i++)
			check_vec();		// must stay quiet all window
		bus_read(gb_map_pkg::ADDR_SC);
		bus_write(gb_map_pkg::ADDR_SC, 8'h00);
		bus_write(gb_map_pkg::ADDR_IE, 8'h00);

		// cartridge passthrough
		for (i = 0; i < 8; i++) begin
			rnd = $random(seed);
			cart_do = rnd[7:0];
			addr = rnd[8] ? (16'hA000 | {3'b000, rnd[28:16]}) : {1'b0, rnd[30:16]};
			bus_write(addr, rnd[15:8]);
			bus_read(addr);
		end
		bus_read(16'h7FFF);
		bus_read(16'hA000);

		repeat (3) step();
		$display("checks done: %0d mismatches, %0d timeouts", err_count, timeouts);
		if (err_count == 0 && timeouts == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== all.f ====
hdl/gb_map_pkg.sv
hdl/gb_bus_pkg.sv
hdl/gb_bus_decode.sv
hdl/gb_irq_ctrl.sv
hdl/gb_joypad.sv
hdl/gb_serial.sv
hdl/gb_work_ram.sv
hdl/gb_io_top.sv
dv/gb_io_checker.sv
dv/tb_gb_io.sv

// ==== run.sh ====
#!/bin/sh
# build and run the io glue testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_gb_io -f all.f -o sim_gb_io
# a crashed run counts as a failure too
./obj_dir/sim_gb_io > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log
if grep -q "Simulation failed" sim.log; then
	echo "run.sh: failure found in sim.log"
	exit 1
fi
echo "run.sh: no failure in sim.log"
